//--- Bender.yml
package:
  name: wave_scope

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/scope_sample_pkg.sv
      - rtl/scope_ctrl_pkg.sv
      - rtl/wave_capture.sv
      - rtl/sample_ram.sv
      - rtl/wave_display.sv
      - rtl/wave_scope.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/wave_scope_assert.sv
      - test/wave_scope_tb.sv

//--- rtl/sample_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "scope_params.svh"

module sample_ram (
    input  wire                       clk,
    input  wire                       write_enable,
    input  wire [`SCOPE_ADDR_W-1:0]   write_address,
    input  wire [`SCOPE_PIXEL_W-1:0]  write_sample,
    input  wire [`SCOPE_ADDR_W-1:0]   read_address,
    output logic [`SCOPE_PIXEL_W-1:0] read_data       // Valid one cycle after read_address
);

    // Two pages of SCOPE_PAGE_DEPTH bytes, page bit on top of the address
    logic [`SCOPE_PIXEL_W-1:0] mem [0:(2**`SCOPE_ADDR_W)-1];

    // Capture writes on the strobe edge
    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_address] <= write_sample;
        end
    end

    // Registered read port
    // Capture and display always sit on different pages, so no collision handling
    always_ff @(posedge clk) begin
        read_data <= mem[read_address];
    end

endmodule

`default_nettype wire

//--- rtl/scope_ctrl_pkg.sv
`default_nettype none

package scope_ctrl_pkg;

    // Trigger machine of the capture side
    typedef enum logic [1:0] {
        CAP_ARMED  = 2'b00,  // Looking for a rising zero crossing
        CAP_ACTIVE = 2'b01,  // Writing one page of samples
        CAP_WAIT   = 2'b10   // Page full and holding until a sweep ends
    } capture_state_e;

    // Sweep machine of the display side
    typedef enum logic {
        DISP_LATCH = 1'b0,   // One cycle to pick up the page to show
        DISP_SWEEP = 1'b1    // Reading the page out to the sink
    } display_state_e;

endpackage

`default_nettype wire

//--- rtl/scope_params.svh
`ifndef SCOPE_PARAMS_SVH
`define SCOPE_PARAMS_SVH

// Width of one audio word as it arrives from the decoder
`define SCOPE_SAMPLE_W 16

// Width of the byte kept per sample and sent to the pixel sink
`define SCOPE_PIXEL_W 8

// Samples captured per trigger, one full page of the RAM
`define SCOPE_PAGE_DEPTH 256

// RAM address width, the top bit selects the page
`define SCOPE_ADDR_W 9

// Credits the pixel sink grants after reset
`define SCOPE_SINK_CREDITS 4

`endif

//--- rtl/scope_sample_pkg.sv
`default_nettype none

`include "scope_params.svh"

package scope_sample_pkg;

    // Field split of one audio word
    // The top byte is sign plus top_bits, the low byte is dropped by the capture
    typedef struct packed {
        logic                                       sign;      // Two's complement sign
        logic [`SCOPE_SAMPLE_W-`SCOPE_PIXEL_W-2:0]  top_bits;  // Rest of the top byte
        logic [`SCOPE_PIXEL_W-1:0]                  low_byte;  // Fine resolution bits
    } audio_fields_t;

    // One audio word seen either as signed PCM or as its fields
    typedef union packed {
        logic signed [`SCOPE_SAMPLE_W-1:0] pcm;     // Arithmetic view
        audio_fields_t                     fields;  // Bit field view
    } audio_word_u;

endpackage

`default_nettype wire

//--- rtl/wave_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "scope_params.svh"

module wave_capture
    import scope_sample_pkg::*;
    import scope_ctrl_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       new_sample_ready,  // One-cycle strobe per audio word
    input  wire audio_word_u          new_sample_in,
    input  wire                       sweep_done,        // Display has sent its last byte
    output logic [`SCOPE_ADDR_W-1:0]  write_address,
    output logic                      write_enable,
    output logic [`SCOPE_PIXEL_W-1:0] write_sample,
    output logic                      read_index         // Page the display is allowed to show
);

    // Address within one page, the page bit is added at the output
    localparam int count_w = `SCOPE_ADDR_W - 1;

    capture_state_e     state;
    capture_state_e     next_state;
    logic [count_w-1:0] wr_count;    // Next slot of the page being filled
    logic               prev_sign;   // Sign of the last strobed sample
    logic               crossing;
    logic               page_full;

    // Rising zero crossing seen between the last strobe and this one
    assign crossing = new_sample_ready && prev_sign && !new_sample_in.fields.sign;

    // Last slot of the page is written in this cycle
    assign page_full = write_enable && (wr_count == count_w'(`SCOPE_PAGE_DEPTH - 1));

    always_comb begin
        next_state = state;
        unique case (state)
            CAP_ARMED: begin
                if (crossing) begin
                    next_state = CAP_ACTIVE;  // The crossing sample itself is not stored
                end
            end
            CAP_ACTIVE: begin
                if (page_full) begin
                    next_state = CAP_WAIT;
                end
            end
            CAP_WAIT: begin
                // Only swap pages once the display is done with the old one
                if (sweep_done) begin
                    next_state = CAP_ARMED;
                end
            end
            default: next_state = CAP_ARMED;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= CAP_ARMED;
            wr_count   <= '0;
            prev_sign  <= 1'b0;
            read_index <= 1'b0;
        end else begin
            state <= next_state;

            // The sign history follows every strobe, whatever the state
            if (new_sample_ready) begin
                prev_sign <= new_sample_in.fields.sign;
            end

            if (state != CAP_ACTIVE) begin
                wr_count <= '0;                  // Each capture starts at slot 0
            end else if (new_sample_ready) begin
                wr_count <= wr_count + 1'b1;     // Wraps to 0 after the last slot
            end

            // The freshly filled page becomes the one on screen
            if ((state == CAP_WAIT) && sweep_done) begin
                read_index <= ~read_index;
            end
        end
    end

    assign write_enable = (state == CAP_ACTIVE) && new_sample_ready;

    // Write into the page the display is not reading
    assign write_address = (state == CAP_ACTIVE) ? {~read_index, wr_count} : '0;

    // Flipping the sign bit turns the signed top byte into an offset unsigned byte
    assign write_sample = (state == CAP_ACTIVE) ?
        {~new_sample_in.fields.sign, new_sample_in.fields.top_bits} : '0;

endmodule

`default_nettype wire

//--- rtl/wave_display.sv
`timescale 1ns/1ps
`default_nettype none

`include "scope_params.svh"

module wave_display
    import scope_ctrl_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       read_index,     // Page released by the capture
    input  wire [`SCOPE_PIXEL_W-1:0]  read_data,      // RAM output, one cycle after the address
    input  wire                       credit_return,  // Sink frees one slot
    output logic [`SCOPE_ADDR_W-1:0]  read_address,
    output logic                      stream_valid,
    output logic [`SCOPE_PIXEL_W-1:0] stream_data,
    output logic                      stream_last,    // Marks the final byte of a sweep
    output logic                      sweep_done
);

    localparam int count_w  = `SCOPE_ADDR_W - 1;
    localparam int credit_w = 3;

    display_state_e      state;
    logic                sweep_page;    // Page latched for the whole sweep
    logic [count_w:0]    rd_count;      // Reads issued so far, one extra bit to count to the end
    logic [credit_w-1:0] credits;       // Slots the sink still has free
    logic                issue;
    logic                all_issued;
    logic                last_q;        // Registered end of sweep

    assign all_issued = (rd_count == (count_w + 1)'(`SCOPE_PAGE_DEPTH));

    // A read goes out only if its byte will still find a credit when it reaches the stream
    // The byte on the stream right now spends one credit this cycle
    assign issue = (state == DISP_SWEEP) && !all_issued &&
                   (credits > {{(credit_w-1){1'b0}}, stream_valid});

    // Address within the latched page
    assign read_address = {sweep_page, rd_count[count_w-1:0]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= DISP_LATCH;
            sweep_page <= 1'b0;
            rd_count   <= '0;
        end else begin
            unique case (state)
                DISP_LATCH: begin
                    sweep_page <= read_index;  // Picks up a swap done on the last sweep end
                    rd_count   <= '0;
                    state      <= DISP_SWEEP;
                end
                DISP_SWEEP: begin
                    if (issue) begin
                        rd_count <= rd_count + 1'b1;
                    end
                    // Stay until the last byte has left so the next latch sees the new page
                    if (last_q) begin
                        state <= DISP_LATCH;
                    end
                end
                default: state <= DISP_LATCH;
            endcase
        end
    end

    // Valid and last follow the read by one cycle, matching the RAM latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stream_valid <= 1'b0;
            last_q       <= 1'b0;
        end else begin
            stream_valid <= issue;
            last_q       <= issue && (rd_count[count_w-1:0] == count_w'(`SCOPE_PAGE_DEPTH - 1));
        end
    end

    // Each valid byte spends a credit and each return gives one back
    // Both can land in the same cycle and cancel out
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= credit_w'(`SCOPE_SINK_CREDITS);
        end else begin
            credits <= credits
                       - {{(credit_w-1){1'b0}}, stream_valid}
                       + {{(credit_w-1){1'b0}}, credit_return};
        end
    end

    assign stream_data = read_data;   // RAM output register is the data stage
    assign stream_last = last_q;
    assign sweep_done  = last_q;      // One-cycle pulse alongside the last byte

endmodule

`default_nettype wire

//--- rtl/wave_scope.sv
`timescale 1ns/1ps
`default_nettype none

`include "scope_params.svh"

module wave_scope
    import scope_sample_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       new_sample_ready,
    input  wire audio_word_u          new_sample_in,
    input  wire                       credit_return,
    output wire                       stream_valid,
    output wire [`SCOPE_PIXEL_W-1:0]  stream_data,
    output wire                       stream_last,
    output wire                       read_index     // Tells the sink which page a sweep shows
);

    wire [`SCOPE_ADDR_W-1:0]  write_address;
    wire                      write_enable;
    wire [`SCOPE_PIXEL_W-1:0] write_sample;
    wire [`SCOPE_ADDR_W-1:0]  read_address;
    wire [`SCOPE_PIXEL_W-1:0] read_data;
    wire                      sweep_done;     // Display tells the capture it may swap pages

    // Trigger and write side
    wave_capture capture_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .new_sample_ready (new_sample_ready),
        .new_sample_in    (new_sample_in),
        .sweep_done       (sweep_done),
        .write_address    (write_address),
        .write_enable     (write_enable),
        .write_sample     (write_sample),
        .read_index       (read_index)
    );

    // Two-page store between the two sides
    sample_ram ram_i (
        .clk           (clk),
        .write_enable  (write_enable),
        .write_address (write_address),
        .write_sample  (write_sample),
        .read_address  (read_address),
        .read_data     (read_data)
    );

    // Sweeps the shown page toward the pixel sink
    wave_display display_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .read_index    (read_index),
        .read_data     (read_data),
        .credit_return (credit_return),
        .read_address  (read_address),
        .stream_valid  (stream_valid),
        .stream_data   (stream_data),
        .stream_last   (stream_last),
        .sweep_done    (sweep_done)
    );

endmodule

`default_nettype wire

//--- test/wave_scope_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "scope_params.svh"

module wave_scope_assert
    import scope_ctrl_pkg::*;
(
    input wire                 clk,
    input wire                 rst_n,
    input wire                 write_enable,   // Capture write strobe
    input wire capture_state_e cap_state,
    input wire [2:0]           credits,        // Display credit counter
    input wire                 sweep_done
);

    // A wrap below zero shows up as a count above the grant
    credit_range_a: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= 3'(`SCOPE_SINK_CREDITS))
    else begin
        $error("Credit counter %0d is outside the granted range", credits);
        wave_scope_tb.errors++;
    end

    // RAM is only written while a page is being filled
    write_state_a: assert property (@(posedge clk) disable iff (!rst_n)
        write_enable |-> (cap_state == CAP_ACTIVE))
    else begin
        $error("Write strobe outside the active capture state");
        wave_scope_tb.errors++;
    end

    // End of sweep is a single-cycle pulse
    sweep_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        sweep_done |=> !sweep_done)
    else begin
        $error("Sweep done held for more than one cycle");
        wave_scope_tb.errors++;
    end

endmodule

`default_nettype wire

//--- test/wave_scope_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "scope_params.svh"

module wave_scope_tb
    import scope_sample_pkg::*;
    import scope_ctrl_pkg::*;
();

    localparam int page_depth   = `SCOPE_PAGE_DEPTH;
    localparam int swaps_wanted = 6;      // Captured pages that must reach the screen
    localparam int max_cycles   = 60000;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     new_sample_ready;
    audio_word_u              new_sample_in;
    logic                     credit_return;
    wire                      stream_valid;
    wire [`SCOPE_PIXEL_W-1:0] stream_data;
    wire                      stream_last;
    wire                      read_index;

    // Reference model of both pages and of the trigger
    logic [`SCOPE_PIXEL_W-1:0] model_page [0:1][0:page_depth-1];
    bit                        page_valid [0:1];   // Page holds a finished capture
    capture_state_e            model_state;
    logic                      model_prev_sign;
    int                        model_wr;
    logic                      model_index;
    logic                      shown_page;          // Page of the sweep now on the stream
    int                        byte_idx;            // Position within that sweep
    int                        since_reset;
    int                        owed_q [$];          // Bytes still waiting for their credit
    int                        bytes_seen;
    int                        swaps       = 0;
    int                        data_checks = 0;
    int                        checks      = 0;
    int                        errors      = 0;

    wave_scope dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .new_sample_ready (new_sample_ready),
        .new_sample_in    (new_sample_in),
        .credit_return    (credit_return),
        .stream_valid     (stream_valid),
        .stream_data      (stream_data),
        .stream_last      (stream_last),
        .read_index       (read_index)
    );

    // Each side gets its own checker with the inputs it does not have tied off
    bind wave_capture wave_scope_assert capture_check_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .write_enable (write_enable),
        .cap_state    (state),
        .credits      (3'(`SCOPE_SINK_CREDITS)),
        .sweep_done   (sweep_done)
    );
    bind wave_display wave_scope_assert display_check_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .write_enable (1'b0),
        .cap_state    (scope_ctrl_pkg::CAP_ARMED),
        .credits      (credits),
        .sweep_done   (sweep_done)
    );

    always #10 clk = ~clk;   // 20 ns period

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    // Mostly small values around zero so crossings come often
    function automatic audio_word_u random_sample();
        audio_word_u w;
        if ($urandom_range(3) == 0) begin
            w.pcm = 16'($urandom);
        end else begin
            w.pcm = 16'(int'($urandom_range(4095)) - 2048);
        end
        return w;
    endfunction

    // Signed top byte shifted up by half the range
    function automatic logic [7:0] expected_byte(input audio_word_u w);
        return 8'((w.pcm >>> 8) + 128);
    endfunction

    task automatic reset_model();
        model_state     = CAP_ARMED;
        model_prev_sign = 1'b0;
        model_wr        = 0;
        model_index     = 1'b0;
        shown_page      = 1'b0;
        byte_idx        = 0;
        since_reset     = 0;
        bytes_seen      = 0;
        page_valid[0]   = 1'b0;
        page_valid[1]   = 1'b0;
        owed_q.delete();
    endtask

    // Trigger rules applied once per clock with the state before the edge
    task automatic step_capture(input logic sweep_end);
        logic sign;
        sign = new_sample_in.pcm < 0;
        if (model_state == CAP_ARMED) begin
            if (new_sample_ready && model_prev_sign && !sign) begin
                model_state = CAP_ACTIVE;                // Crossing sample is not kept
                model_wr    = 0;
                page_valid[~model_index] = 1'b0;
            end
        end else if (model_state == CAP_ACTIVE) begin
            if (new_sample_ready) begin
                model_page[~model_index][model_wr] = expected_byte(new_sample_in);
                model_wr++;
                if (model_wr == page_depth) begin
                    model_state = CAP_WAIT;
                    page_valid[~model_index] = 1'b1;
                end
            end
        end else if (sweep_end) begin
            model_state = CAP_ARMED;                     // Swap only after a full sweep
            model_index = ~model_index;
            swaps++;
        end
        if (new_sample_ready) begin
            model_prev_sign = sign;
        end
    endtask

    task automatic check_stream();
        if (stream_valid) begin
            if (page_valid[shown_page]) begin
                check_value("stream_data", stream_data, model_page[shown_page][byte_idx]);
                data_checks++;
            end
            check_value("stream_last", stream_last, byte_idx == page_depth - 1);
            byte_idx = (stream_last || byte_idx == page_depth - 1) ? 0 : byte_idx + 1;
        end else begin
            check_value("stream_last", stream_last, 1'b0);
        end
    endtask

    task automatic count_credits();
        if (stream_valid) begin
            owed_q.push_back(bytes_seen);
            bytes_seen++;
        end
        if (credit_return) begin
            void'(owed_q.pop_front());
        end
        checks++;
        assert (owed_q.size() <= `SCOPE_SINK_CREDITS) else begin
            errors++;
            $display("At %0t the sink holds %0d bytes, more than its credits", $time,
                     owed_q.size());
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            reset_model();
        end else begin
            check_value("read_index", read_index, model_index);
            if (since_reset < 2) begin
                check_value("stream_valid", stream_valid, 1'b0);  // Latch cycle comes first
            end
            check_stream();
            step_capture(stream_valid && stream_last);
            if (stream_valid && stream_last) begin
                shown_page = model_index;   // Next latch sees the page after any swap
            end
            count_credits();
            since_reset++;
        end
    end

    initial begin
        int cycles;
        bit timed_out;
        void'($urandom(39091));
        rst_n            = 1'b0;
        new_sample_ready = 1'b0;
        new_sample_in    = '0;
        credit_return    = 1'b0;
        repeat (16) begin
            @(negedge clk);
            check_value("stream_valid", stream_valid, 1'b0);
            check_value("read_index", read_index, 1'b0);
        end
        rst_n     = 1'b1;
        cycles    = 0;
        timed_out = 1'b0;
        while (swaps < swaps_wanted && !timed_out) begin
            @(negedge clk);
            new_sample_ready = ($urandom_range(2) == 0);   // About one cycle in three
            if (new_sample_ready) begin
                new_sample_in = random_sample();
            end
            credit_return = (owed_q.size() > 0) && ($urandom_range(1) == 0);
            cycles++;
            timed_out = (cycles >= max_cycles);
        end
        if (timed_out) begin
            errors++;
            $display("Timed out after %0d cycles with only %0d page swaps", cycles, swaps);
        end
        checks++;
        assert (data_checks > 0) else begin
            errors++;
            $display("No byte of a captured page ever reached the sink");
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- wave_scope.f
+incdir+rtl
rtl/scope_sample_pkg.sv
rtl/scope_ctrl_pkg.sv
rtl/wave_capture.sv
rtl/sample_ram.sv
rtl/wave_display.sv
rtl/wave_scope.sv
test/wave_scope_assert.sv
test/wave_scope_tb.sv
